//--- npc_mem.f
rtl/npc_mem_pkg.sv
rtl/axi_if.sv
rtl/npc_mem_array.sv
rtl/npc_ram.sv
rtl/npc_axi_arbiter.sv
rtl/npc_mem_top.sv
tests/tb_clock.sv
tests/npc_mem_tb.sv

//--- rtl/axi_if.sv
`timescale 1ns/1ns

interface axi_if;
  import npc_mem_pkg::*;

  // read address and read data
  logic              arvalid;
  logic              arready;
  logic [ADDR_W-1:0] araddr;
  logic              rvalid;
  logic              rready;
  logic [DATA_W-1:0] rdata;
  logic [RESP_W-1:0] rresp;

  // write address, write data and write response
  logic              awvalid;
  logic              awready;
  logic [ADDR_W-1:0] awaddr;
  logic              wvalid;
  logic              wready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              bvalid;
  logic              bready;
  logic [RESP_W-1:0] bresp;

  modport master (
    output arvalid, araddr, rready,
    output awvalid, awaddr, wvalid, wdata, wstrb, bready,
    input  arready, rvalid, rdata, rresp,
    input  awready, wready, bvalid, bresp
  );

  modport slave (
    input  arvalid, araddr, rready,
    input  awvalid, awaddr, wvalid, wdata, wstrb, bready,
    output arready, rvalid, rdata, rresp,
    output awready, wready, bvalid, bresp
  );

endinterface

//--- rtl/npc_axi_arbiter.sv
`timescale 1ns/1ns

module npc_axi_arbiter (
  input logic   clk,
  input logic   rstn,
  axi_if.slave  ifu,
  axi_if.slave  lsu,
  axi_if.master mem
);
  import npc_mem_pkg::*;

  logic   busy;
  owner_t owner;
  logic   ifu_req;
  logic   lsu_req;
  logic   sel_ifu;
  logic   sel_lsu;
  logic   done;

  assign ifu_req = ifu.arvalid | ifu.awvalid | ifu.wvalid;
  assign lsu_req = lsu.arvalid | lsu.awvalid | lsu.wvalid;

  assign sel_ifu = busy && (owner == OWNER_IFU);
  assign sel_lsu = busy && (owner == OWNER_LSU);

  // the R or B handshake closes the single transaction of the owner
  assign done = (mem.rvalid & mem.rready) | (mem.bvalid & mem.bready);

  ////////////////////////////////////////////////////////////////////////////
  // grant register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rstn) begin
      busy  <= 1'b0;
      owner <= OWNER_IFU;
    end else if (!busy) begin
      if (ifu_req || lsu_req) begin
        busy  <= 1'b1;
        owner <= lsu_req ? OWNER_LSU : OWNER_IFU;   // load/store wins a tie
      end
    end else if (done) begin
      busy <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // requester to memory
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mem.arvalid = 1'b0;
    mem.rready  = 1'b0;
    mem.awvalid = 1'b0;
    mem.wvalid  = 1'b0;
    mem.bready  = 1'b0;
    if (sel_lsu) begin
      mem.arvalid = lsu.arvalid;
      mem.rready  = lsu.rready;
      mem.awvalid = lsu.awvalid;
      mem.wvalid  = lsu.wvalid;
      mem.bready  = lsu.bready;
    end else if (sel_ifu) begin
      mem.arvalid = ifu.arvalid;
      mem.rready  = ifu.rready;
      mem.awvalid = ifu.awvalid;
      mem.wvalid  = ifu.wvalid;
      mem.bready  = ifu.bready;
    end
  end

  // payloads only matter next to a valid, so they follow the owner alone
  assign mem.araddr = (owner == OWNER_LSU) ? lsu.araddr : ifu.araddr;
  assign mem.awaddr = (owner == OWNER_LSU) ? lsu.awaddr : ifu.awaddr;
  assign mem.wdata  = (owner == OWNER_LSU) ? lsu.wdata  : ifu.wdata;
  assign mem.wstrb  = (owner == OWNER_LSU) ? lsu.wstrb  : ifu.wstrb;

  ////////////////////////////////////////////////////////////////////////////
  // memory back to requesters
  ////////////////////////////////////////////////////////////////////////////

  assign ifu.arready = sel_ifu & mem.arready;
  assign ifu.rvalid  = sel_ifu & mem.rvalid;
  assign ifu.awready = sel_ifu & mem.awready;
  assign ifu.wready  = sel_ifu & mem.wready;
  assign ifu.bvalid  = sel_ifu & mem.bvalid;
  assign ifu.rdata   = mem.rdata;
  assign ifu.rresp   = mem.rresp;
  assign ifu.bresp   = mem.bresp;

  assign lsu.arready = sel_lsu & mem.arready;
  assign lsu.rvalid  = sel_lsu & mem.rvalid;
  assign lsu.awready = sel_lsu & mem.awready;
  assign lsu.wready  = sel_lsu & mem.wready;
  assign lsu.bvalid  = sel_lsu & mem.bvalid;
  assign lsu.rdata   = mem.rdata;
  assign lsu.rresp   = mem.rresp;
  assign lsu.bresp   = mem.bresp;

  // a response routed to the wrong requester would follow from a mid-flight switch
  a_owner_stable: assert property (@(posedge clk) disable iff (rstn)
    mem.rvalid || mem.bvalid |-> busy && $stable(owner));

endmodule

//--- rtl/npc_mem_array.sv
`timescale 1ns/1ns

module npc_mem_array (
  input  logic                             clk,
  input  logic                             rd_en,
  input  logic [npc_mem_pkg::IDX_W-1:0]    rd_index,
  output logic [npc_mem_pkg::DATA_W-1:0]   rd_data,
  input  logic                             wr_en,
  input  logic [npc_mem_pkg::IDX_W-1:0]    wr_index,
  input  logic [npc_mem_pkg::DATA_W-1:0]   wr_data,
  input  logic [npc_mem_pkg::STRB_W-1:0]   wr_strb
);
  import npc_mem_pkg::*;

  logic [DATA_W-1:0] mem [MEM_WORDS];

  // byte lanes are written independently under the strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int i = 0; i < STRB_W; i++) begin
        if (wr_strb[i]) begin
          mem[wr_index][i*8 +: 8] <= wr_data[i*8 +: 8];
        end
      end
    end
  end

  // read word shows up the cycle after rd_en and holds until the next one
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

endmodule

//--- rtl/npc_mem_pkg.sv
package npc_mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W = 32;
  localparam int DATA_W = 64;
  localparam int STRB_W = 8;
  localparam int RESP_W = 2;

  // 1024 words of 64 bits, so the index comes from address bits 12 down to 3
  localparam int MEM_WORDS = 1024;
  localparam int IDX_W     = $clog2(MEM_WORDS);
  localparam int IDX_LSB   = $clog2(STRB_W);   // byte offset inside a word is dropped

  // no error responses in this subsystem
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // arbitration
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    OWNER_IFU = 1'b0,
    OWNER_LSU = 1'b1
  } owner_t;

endpackage

//--- rtl/npc_mem_top.sv
`timescale 1ns/1ns

module npc_mem_top (
  input  logic                             clk,
  input  logic                             rstn,

  // fetch, read only
  input  logic                             ifu_arvalid,
  output logic                             ifu_arready,
  input  logic [npc_mem_pkg::ADDR_W-1:0]   ifu_araddr,
  output logic                             ifu_rvalid,
  input  logic                             ifu_rready,
  output logic [npc_mem_pkg::DATA_W-1:0]   ifu_rdata,
  output logic [npc_mem_pkg::RESP_W-1:0]   ifu_rresp,

  // load/store
  input  logic                             lsu_arvalid,
  output logic                             lsu_arready,
  input  logic [npc_mem_pkg::ADDR_W-1:0]   lsu_araddr,
  output logic                             lsu_rvalid,
  input  logic                             lsu_rready,
  output logic [npc_mem_pkg::DATA_W-1:0]   lsu_rdata,
  output logic [npc_mem_pkg::RESP_W-1:0]   lsu_rresp,
  input  logic                             lsu_awvalid,
  output logic                             lsu_awready,
  input  logic [npc_mem_pkg::ADDR_W-1:0]   lsu_awaddr,
  input  logic                             lsu_wvalid,
  output logic                             lsu_wready,
  input  logic [npc_mem_pkg::DATA_W-1:0]   lsu_wdata,
  input  logic [npc_mem_pkg::STRB_W-1:0]   lsu_wstrb,
  output logic                             lsu_bvalid,
  input  logic                             lsu_bready,
  output logic [npc_mem_pkg::RESP_W-1:0]   lsu_bresp
);

  axi_if ifu_bus ();
  axi_if lsu_bus ();
  axi_if mem_bus ();

  assign ifu_bus.arvalid = ifu_arvalid;
  assign ifu_bus.araddr  = ifu_araddr;
  assign ifu_bus.rready  = ifu_rready;
  assign ifu_arready     = ifu_bus.arready;
  assign ifu_rvalid      = ifu_bus.rvalid;
  assign ifu_rdata       = ifu_bus.rdata;
  assign ifu_rresp       = ifu_bus.rresp;

  // fetch never writes
  assign ifu_bus.awvalid = 1'b0;
  assign ifu_bus.awaddr  = '0;
  assign ifu_bus.wvalid  = 1'b0;
  assign ifu_bus.wdata   = '0;
  assign ifu_bus.wstrb   = '0;
  assign ifu_bus.bready  = 1'b0;

  assign lsu_bus.arvalid = lsu_arvalid;
  assign lsu_bus.araddr  = lsu_araddr;
  assign lsu_bus.rready  = lsu_rready;
  assign lsu_bus.awvalid = lsu_awvalid;
  assign lsu_bus.awaddr  = lsu_awaddr;
  assign lsu_bus.wvalid  = lsu_wvalid;
  assign lsu_bus.wdata   = lsu_wdata;
  assign lsu_bus.wstrb   = lsu_wstrb;
  assign lsu_bus.bready  = lsu_bready;
  assign lsu_arready     = lsu_bus.arready;
  assign lsu_rvalid      = lsu_bus.rvalid;
  assign lsu_rdata       = lsu_bus.rdata;
  assign lsu_rresp       = lsu_bus.rresp;
  assign lsu_awready     = lsu_bus.awready;
  assign lsu_wready      = lsu_bus.wready;
  assign lsu_bvalid      = lsu_bus.bvalid;
  assign lsu_bresp       = lsu_bus.bresp;

  npc_axi_arbiter npc_axi_arbiter_i (
    .clk  (clk),
    .rstn (rstn),
    .ifu  (ifu_bus.slave),
    .lsu  (lsu_bus.slave),
    .mem  (mem_bus.master)
  );

  npc_ram npc_ram_i (
    .clk  (clk),
    .rstn (rstn),
    .bus  (mem_bus.slave)
  );

endmodule

//--- rtl/npc_ram.sv
`timescale 1ns/1ns

module npc_ram (
  input logic  clk,
  input logic  rstn,
  axi_if.slave bus
);
  import npc_mem_pkg::*;

  logic              reading;   // array read issued, data lands next edge
  logic              rd_wait;   // array data valid, rvalid goes up next edge
  logic [IDX_W-1:0]  rd_index;
  logic [DATA_W-1:0] rd_data;

  logic              waddr_handshake;
  logic              waddr_valid_reg;
  logic              waddr_valid;
  logic [ADDR_W-1:0] waddr_reg;
  logic [ADDR_W-1:0] waddr;

  logic              wdata_handshake;
  logic              wdata_valid_reg;
  logic              wdata_valid;
  logic [DATA_W-1:0] wdata_reg;
  logic [STRB_W-1:0] wstrb_reg;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;

  logic              write_en;
  logic [IDX_W-1:0]  wr_index;

  assign bus.rresp = RESP_OKAY;
  assign bus.bresp = RESP_OKAY;

  ////////////////////////////////////////////////////////////////////////////
  // read path
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rstn) begin
      bus.arready <= 1'b1;
      bus.rvalid  <= 1'b0;
      reading     <= 1'b0;
      rd_wait     <= 1'b0;
    end else begin
      if (bus.rvalid && bus.rready) bus.rvalid <= 1'b0;
      if (bus.arready && bus.arvalid) begin
        bus.arready <= 1'b0;
        reading     <= 1'b1;
      end
      if (reading) begin
        reading <= 1'b0;
        rd_wait <= 1'b1;
      end
      if (rd_wait) begin
        rd_wait     <= 1'b0;
        bus.rvalid  <= 1'b1;
        bus.arready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.arready && bus.arvalid) rd_index <= bus.araddr[IDX_LSB +: IDX_W];
    if (rd_wait) bus.rdata <= rd_data;   // held here while rready is low
  end

  ////////////////////////////////////////////////////////////////////////////
  // write path where address and data may arrive in either order
  ////////////////////////////////////////////////////////////////////////////

  assign waddr_handshake = bus.awready & bus.awvalid;
  assign waddr           = waddr_handshake ? bus.awaddr : waddr_reg;
  assign waddr_valid     = waddr_handshake | waddr_valid_reg;

  assign wdata_handshake = bus.wready & bus.wvalid;
  assign wdata           = wdata_handshake ? bus.wdata : wdata_reg;
  assign wstrb           = wdata_handshake ? bus.wstrb : wstrb_reg;
  assign wdata_valid     = wdata_handshake | wdata_valid_reg;

  assign write_en = waddr_valid & wdata_valid;
  assign wr_index = waddr[IDX_LSB +: IDX_W];

  always_ff @(posedge clk) begin
    if (rstn) begin
      bus.awready     <= 1'b1;
      bus.wready      <= 1'b1;
      bus.bvalid      <= 1'b0;
      waddr_valid_reg <= 1'b0;
      wdata_valid_reg <= 1'b0;
    end else begin
      if (bus.bvalid && bus.bready) bus.bvalid <= 1'b0;
      if (waddr_handshake) begin
        bus.awready     <= 1'b0;
        waddr_valid_reg <= 1'b1;
      end
      if (wdata_handshake) begin
        bus.wready      <= 1'b0;
        wdata_valid_reg <= 1'b1;
      end
      if (write_en) begin   // overrides the captures above when both meet
        bus.bvalid      <= 1'b1;
        bus.awready     <= 1'b1;
        bus.wready      <= 1'b1;
        waddr_valid_reg <= 1'b0;
        wdata_valid_reg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (waddr_handshake) waddr_reg <= bus.awaddr;
    if (wdata_handshake) begin
      wdata_reg <= bus.wdata;
      wstrb_reg <= bus.wstrb;
    end
  end

  npc_mem_array npc_mem_array_i (
    .clk      (clk),
    .rd_en    (reading),
    .rd_index (rd_index),
    .rd_data  (rd_data),
    .wr_en    (write_en),
    .wr_index (wr_index),
    .wr_data  (wdata),
    .wr_strb  (wstrb)
  );

  // a read sampling the array on the edge its word is written would return
  // stale data, the arbiter must keep the two apart
  a_no_rw_collision: assert property (@(posedge clk) disable iff (rstn)
    $rose(bus.rvalid) |-> !$past(reading && write_en && wr_index == rd_index, 2));

  // a second write finishing under a held response would swallow that response
  a_bvalid_hold: assert property (@(posedge clk) disable iff (rstn)
    bus.bvalid && !bus.bready |=> bus.bvalid && !$past(write_en));

endmodule

//--- run.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f npc_mem.f --top-module npc_mem_tb \
  -o npc_mem_sim > build.log 2>&1 \
  || { cat build.log; echo "build error"; exit 1; }

./obj_dir/npc_mem_sim > sim.log 2>&1 \
  || { cat sim.log; echo "simulation aborted"; exit 1; }
cat sim.log

grep -q "Some tests failed" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0

//--- tests/npc_mem_tb.sv
`timescale 1ns/1ns

module npc_mem_tb;
  import npc_mem_pkg::*;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int N_WRITES       = 20;
  localparam int N_SHARED       = 6;

  // handshake selectors for await_transfer
  localparam int CH_IFU_AR     = 0;
  localparam int CH_IFU_R      = 1;
  localparam int CH_LSU_AR     = 2;
  localparam int CH_LSU_R      = 3;
  localparam int CH_LSU_AW     = 4;
  localparam int CH_LSU_W      = 5;
  localparam int CH_LSU_AW_W   = 6;   // both on the same edge
  localparam int CH_LSU_B      = 7;
  localparam int CH_LSU_RVALID = 8;
  localparam int CH_LSU_BVALID = 9;

  localparam int ORDER_TOGETHER = 0;
  localparam int ORDER_AW_FIRST = 1;
  localparam int ORDER_W_FIRST  = 2;

  logic              clk;
  logic              rstn;
  logic              ifu_arvalid;
  logic              ifu_arready;
  logic [ADDR_W-1:0] ifu_araddr;
  logic              ifu_rvalid;
  logic              ifu_rready;
  logic [DATA_W-1:0] ifu_rdata;
  logic [RESP_W-1:0] ifu_rresp;
  logic              lsu_arvalid;
  logic              lsu_arready;
  logic [ADDR_W-1:0] lsu_araddr;
  logic              lsu_rvalid;
  logic              lsu_rready;
  logic [DATA_W-1:0] lsu_rdata;
  logic [RESP_W-1:0] lsu_rresp;
  logic              lsu_awvalid;
  logic              lsu_awready;
  logic [ADDR_W-1:0] lsu_awaddr;
  logic              lsu_wvalid;
  logic              lsu_wready;
  logic [DATA_W-1:0] lsu_wdata;
  logic [STRB_W-1:0] lsu_wstrb;
  logic              lsu_bvalid;
  logic              lsu_bready;
  logic [RESP_W-1:0] lsu_bresp;

  logic [DATA_W-1:0] model [int unsigned];   // expected contents by word index
  logic [ADDR_W-1:0] written [$];
  logic [ADDR_W-1:0] shared_wr [$];
  logic [31:0]       lcg_state;
  logic [ADDR_W-1:0] lsu_rd_addr;
  logic [ADDR_W-1:0] ifu_rd_addr;
  int                errors;
  int                tests_run;
  int                tests_bad;
  int                lsu_r_count;
  int                lsu_b_count;
  int                ifu_r_count;

  tb_clock tb_clock_i (.clk(clk));

  npc_mem_top npc_mem_top_i (
    .clk         (clk),
    .rstn        (rstn),
    .ifu_arvalid (ifu_arvalid),
    .ifu_arready (ifu_arready),
    .ifu_araddr  (ifu_araddr),
    .ifu_rvalid  (ifu_rvalid),
    .ifu_rready  (ifu_rready),
    .ifu_rdata   (ifu_rdata),
    .ifu_rresp   (ifu_rresp),
    .lsu_arvalid (lsu_arvalid),
    .lsu_arready (lsu_arready),
    .lsu_araddr  (lsu_araddr),
    .lsu_rvalid  (lsu_rvalid),
    .lsu_rready  (lsu_rready),
    .lsu_rdata   (lsu_rdata),
    .lsu_rresp   (lsu_rresp),
    .lsu_awvalid (lsu_awvalid),
    .lsu_awready (lsu_awready),
    .lsu_awaddr  (lsu_awaddr),
    .lsu_wvalid  (lsu_wvalid),
    .lsu_wready  (lsu_wready),
    .lsu_wdata   (lsu_wdata),
    .lsu_wstrb   (lsu_wstrb),
    .lsu_bvalid  (lsu_bvalid),
    .lsu_bready  (lsu_bready),
    .lsu_bresp   (lsu_bresp)
  );

  ////////////////////////////////////////////////////////////////////////////
  // reference model and random numbers
  ////////////////////////////////////////////////////////////////////////////

  function automatic int unsigned word_index(input logic [ADDR_W-1:0] addr);
    return (addr >> 3) % MEM_WORDS;   // addresses wrap around the array
  endfunction

  function automatic void model_write(input logic [ADDR_W-1:0] addr,
                                      input logic [DATA_W-1:0] data,
                                      input logic [STRB_W-1:0] strb);
    int unsigned       idx;
    logic [DATA_W-1:0] mask;
    logic [DATA_W-1:0] word;
    idx = word_index(addr);
    for (int b = 0; b < STRB_W; b++) begin
      mask[b*8 +: 8] = {8{strb[b]}};
    end
    // a partial write leaves an unwritten word partly unknown, so it stays out
    if (model.exists(idx) || strb == '1) begin
      word = model.exists(idx) ? model[idx] : '0;
      model[idx] = (word & ~mask) | (data & mask);
    end
  endfunction

  function automatic bit known_word(input logic [ADDR_W-1:0] addr);
    return model.exists(word_index(addr)) != 0;
  endfunction

  function automatic logic [DATA_W-1:0] expected_word(input logic [ADDR_W-1:0] addr);
    return model[word_index(addr)];
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] random_word();
    logic [DATA_W-1:0] w;
    w[63:32] = lcg_next();
    w[31:0]  = lcg_next();
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic bit fires(input int ch);
    case (ch)
      CH_IFU_AR:     return ifu_arvalid && ifu_arready;
      CH_IFU_R:      return ifu_rvalid && ifu_rready;
      CH_LSU_AR:     return lsu_arvalid && lsu_arready;
      CH_LSU_R:      return lsu_rvalid && lsu_rready;
      CH_LSU_AW:     return lsu_awvalid && lsu_awready;
      CH_LSU_W:      return lsu_wvalid && lsu_wready;
      CH_LSU_AW_W:   return lsu_awvalid && lsu_awready && lsu_wvalid && lsu_wready;
      CH_LSU_B:      return lsu_bvalid && lsu_bready;
      CH_LSU_RVALID: return lsu_rvalid;
      CH_LSU_BVALID: return lsu_bvalid;
      default:       return 1'b0;
    endcase
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  // returns 1 ns after the edge on which the transfer happens
  task automatic await_transfer(input int ch, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (!fires(ch) && n < TIMEOUT_CYCLES) begin
      @(negedge clk);
      n++;
    end
    if (!fires(ch)) begin
      $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
      errors++;
    end
    @(posedge clk);
    #1;
  endtask

  task automatic skip_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic ifu_read(input logic [ADDR_W-1:0] addr);
    ifu_rd_addr = addr;
    ifu_araddr  = addr;
    ifu_arvalid = 1'b1;
    await_transfer(CH_IFU_AR, "fetch AR handshake");
    ifu_arvalid = 1'b0;
    ifu_rready  = 1'b1;
    await_transfer(CH_IFU_R, "fetch R handshake");
    ifu_rready = 1'b0;
  endtask

  task automatic lsu_read(input logic [ADDR_W-1:0] addr, input int hold);
    logic [DATA_W-1:0] held;
    lsu_rd_addr = addr;
    lsu_araddr  = addr;
    lsu_arvalid = 1'b1;
    await_transfer(CH_LSU_AR, "lsu AR handshake");
    lsu_arvalid = 1'b0;
    if (hold > 0) begin   // keep rready low and watch the response sit still
      await_transfer(CH_LSU_RVALID, "lsu rvalid");
      held = lsu_rdata;
      repeat (hold) begin
        @(negedge clk);
        if (lsu_rvalid !== 1'b1 || lsu_rdata !== held)
          flag_mismatch("lsu rvalid or rdata changed while rready was low");
      end
      @(posedge clk);
      #1;
    end
    lsu_rready = 1'b1;
    await_transfer(CH_LSU_R, "lsu R handshake");
    lsu_rready = 1'b0;
  endtask

  task automatic lsu_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb, input int order, input int hold);
    lsu_awaddr = addr;
    lsu_wdata  = data;
    lsu_wstrb  = strb;
    if (order == ORDER_AW_FIRST) begin
      lsu_awvalid = 1'b1;
      await_transfer(CH_LSU_AW, "lsu AW handshake");
      lsu_awvalid = 1'b0;
      lsu_wvalid  = 1'b1;
      await_transfer(CH_LSU_W, "lsu W handshake");
      lsu_wvalid = 1'b0;
    end else if (order == ORDER_W_FIRST) begin
      lsu_wvalid = 1'b1;
      await_transfer(CH_LSU_W, "lsu W handshake");
      lsu_wvalid  = 1'b0;
      lsu_awvalid = 1'b1;
      await_transfer(CH_LSU_AW, "lsu AW handshake");
      lsu_awvalid = 1'b0;
    end else begin
      lsu_awvalid = 1'b1;
      lsu_wvalid  = 1'b1;
      await_transfer(CH_LSU_AW_W, "lsu AW and W handshake");
      lsu_awvalid = 1'b0;
      lsu_wvalid  = 1'b0;
    end
    if (hold > 0) begin
      await_transfer(CH_LSU_BVALID, "lsu bvalid");
      repeat (hold) begin
        @(negedge clk);
        if (lsu_bvalid !== 1'b1)
          flag_mismatch("lsu bvalid dropped while bready was low");
      end
      @(posedge clk);
      #1;
    end
    lsu_bready = 1'b1;
    await_transfer(CH_LSU_B, "lsu B handshake");
    lsu_bready = 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic close_test(input int num, input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_bad++;
      $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // checker that samples one half period before the transfer edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rstn && lsu_rvalid && lsu_rready) begin
      lsu_r_count++;
      if (lsu_rresp !== RESP_OKAY)
        flag_mismatch($sformatf("lsu rresp is %0d", lsu_rresp));
      if (known_word(lsu_rd_addr) && lsu_rdata !== expected_word(lsu_rd_addr))
        flag_mismatch($sformatf("lsu read of %h gave %h, expected %h",
                                lsu_rd_addr, lsu_rdata, expected_word(lsu_rd_addr)));
    end
    if (!rstn && ifu_rvalid && ifu_rready) begin
      ifu_r_count++;
      if (ifu_rresp !== RESP_OKAY)
        flag_mismatch($sformatf("fetch rresp is %0d", ifu_rresp));
      if (known_word(ifu_rd_addr) && ifu_rdata !== expected_word(ifu_rd_addr))
        flag_mismatch($sformatf("fetch of %h gave %h, expected %h",
                                ifu_rd_addr, ifu_rdata, expected_word(ifu_rd_addr)));
    end
    if (!rstn && lsu_bvalid && lsu_bready) begin
      lsu_b_count++;
      if (lsu_bresp !== RESP_OKAY)
        flag_mismatch($sformatf("lsu bresp is %0d", lsu_bresp));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int          e0;
    int          r0;
    int          b0;
    int          f0;
    bit          clash;
    logic [31:0] rnd;
    logic [ADDR_W-1:0] addr;
    rstn        = 1'b1;
    ifu_arvalid = 1'b0;
    ifu_araddr  = '0;
    ifu_rready  = 1'b0;
    lsu_arvalid = 1'b0;
    lsu_araddr  = '0;
    lsu_rready  = 1'b0;
    lsu_awvalid = 1'b0;
    lsu_awaddr  = '0;
    lsu_wvalid  = 1'b0;
    lsu_wdata   = '0;
    lsu_wstrb   = '0;
    lsu_bready  = 1'b0;
    lcg_state   = 32'd23979;
    errors      = 0;
    tests_run   = 0;
    tests_bad   = 0;
    lsu_r_count = 0;
    lsu_b_count = 0;
    ifu_r_count = 0;
    ifu_rd_addr = '0;
    lsu_rd_addr = '0;

    repeat (8) @(posedge clk);
    #1;
    rstn = 1'b0;

    e0 = errors;
    @(negedge clk);
    if (lsu_rvalid !== 1'b0 || lsu_bvalid !== 1'b0 || ifu_rvalid !== 1'b0)
      flag_mismatch("a response valid is high after reset");
    if (lsu_arready !== 1'b0 || lsu_awready !== 1'b0 || ifu_arready !== 1'b0)
      flag_mismatch("a ready is high before any grant");
    skip_cycles(1);
    close_test(1, "reset state", e0);

    e0 = errors;
    r0 = lsu_r_count;
    for (int i = 0; i < N_WRITES; i++) begin
      addr = lcg_next();
      written.push_back(addr);
      lsu_write(addr, random_word(), '1, ORDER_TOGETHER, 0);
      lsu_read(addr, 0);
    end
    if (lsu_r_count - r0 != N_WRITES)
      flag_mismatch($sformatf("%0d lsu reads completed, expected %0d", lsu_r_count - r0, N_WRITES));
    close_test(2, "full-word write and read", e0);

    e0 = errors;
    for (int i = 0; i < 12; i++) begin
      rnd = lcg_next();
      lsu_write(written[i], random_word(), rnd[15:8], ORDER_TOGETHER, 0);
      lsu_read(written[i], 0);
    end
    close_test(3, "byte-masked writes", e0);

    e0 = errors;
    for (int order = 0; order < 3; order++) begin
      for (int i = 0; i < 3; i++) begin
        rnd  = lcg_next();
        addr = written[rnd % N_WRITES];
        b0   = lsu_b_count;
        lsu_write(addr, random_word(), rnd[23:16], order, 0);
        skip_cycles(3);
        if (lsu_b_count - b0 != 1 || lsu_bvalid !== 1'b0)
          flag_mismatch($sformatf("order %0d gave %0d write responses", order, lsu_b_count - b0));
        lsu_read(addr, 0);
      end
    end
    close_test(4, "address and data order", e0);

    // write targets stay clear of the words that fetch reads in this round
    e0 = errors;
    while (shared_wr.size() < N_SHARED) begin
      addr  = lcg_next();
      clash = 1'b0;
      for (int k = 0; k < N_SHARED; k++) begin
        if (word_index(addr) == word_index(written[k])) clash = 1'b1;
      end
      if (!clash) shared_wr.push_back(addr);
    end
    r0 = lsu_r_count;
    b0 = lsu_b_count;
    f0 = ifu_r_count;
    fork
      begin
        for (int i = 0; i < N_SHARED; i++) ifu_read(written[i]);
      end
      begin
        logic [31:0] gap_rnd;
        for (int i = 0; i < N_SHARED; i++) begin
          lsu_write(shared_wr[i], random_word(), '1, ORDER_TOGETHER, 0);
          gap_rnd = lcg_next();
          skip_cycles(gap_rnd[0] ? 2 : 1);
        end
      end
    join
    if (ifu_r_count - f0 != N_SHARED || lsu_b_count - b0 != N_SHARED || lsu_r_count != r0)
      flag_mismatch($sformatf("responses: %0d fetch, %0d write, %0d lsu read",
                              ifu_r_count - f0, lsu_b_count - b0, lsu_r_count - r0));
    close_test(5, "shared access", e0);

    e0 = errors;
    addr = written[N_WRITES - 1];
    lsu_write(addr, random_word(), '1, ORDER_TOGETHER, 5);
    lsu_read(addr, 5);
    close_test(6, "back-pressure", e0);

    $display("closing: %0d tests run, %0d with errors, %0d errors in total",
             tests_run, tests_bad, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic clk
);

  // 100 ns period
  initial clk = 1'b0;

  always #50 clk = ~clk;

endmodule
